// File: vlog.f
rtl/srpt_pkg.sv
rtl/srpt_header_intake.sv
rtl/srpt_queue.sv
rtl/srpt_active_set.sv
rtl/srpt_grant_top.sv
bench/tb_clock.sv
bench/srpt_chk.sv
bench/srpt_tb.sv

// File: Makefile
# Verilator simulation of the SRPT grant scheduler

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = srpt_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the log decides the result, the binary status is not used
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/srpt_tb.sv
module srpt_tb;
   import srpt_pkg::*;

   localparam int QUEUE_DEPTH    = 16;
   localparam int MAX_OVERCOMMIT = 4;
   localparam int MIX_HEADERS    = 150;
   // all headers of all tests, drain retires included
   localparam int TOTAL_HEADERS  = 8 + QUEUE_DEPTH + 2 * MAX_OVERCOMMIT + MIX_HEADERS + 64;
   localparam int TIMEOUT_CYCLES = TOTAL_HEADERS * QUEUE_DEPTH + 1000;

   logic         ap_clk;
   logic         ap_rst;
   logic         header_valid_i;
   srpt_header_t header_i;
   logic         grant_full_i;
   logic         grant_valid_o;
   srpt_entry_t  grant_o;

   // model, messages waiting and messages granted
   srpt_entry_t          pending[$];
   srpt_entry_t          outstanding[$];
   int                   grant_count = 0;
   bit                   strict_order = 1'b0;
   logic                 full_at_edge = 1'b0;
   logic [PEER_ID_W-1:0] next_peer = PEER_ID_W'(1);

   tb_clock #(.PERIOD(4)) u_clock (.clk_o(ap_clk));

   srpt_grant_top #(
      .QUEUE_DEPTH    (QUEUE_DEPTH),
      .MAX_OVERCOMMIT (MAX_OVERCOMMIT)
   ) UUT (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_valid_i (header_valid_i),
      .header_i       (header_i),
      .grant_full_i   (grant_full_i),
      .grant_valid_o  (grant_valid_o),
      .grant_o        (grant_o)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("** Error at time %0t: %s = 0x%0h, expected 0x%0h",
                            $time, name, actual, expected));
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(posedge ap_clk);
   endtask

   // one-cycle header strobe, driven on the falling edge
   task automatic send_header(input logic [PEER_ID_W-1:0] peer, input logic [RPC_ID_W-1:0] rpc,
                              input int len, input int inc, input logic [OFFSET_W-1:0] offset);
      @(negedge ap_clk);
      header_valid_i    = 1'b1;
      header_i.peer_id  = peer;
      header_i.rpc_id   = rpc;
      header_i.msg_len  = PKTS_W'(len);
      header_i.incoming = PKTS_W'(inc);
      header_i.offset   = offset;
      @(negedge ap_clk);
      header_valid_i = 1'b0;
   endtask

   // first packet of a message, unique peer id
   task automatic new_message(input int len);
      srpt_entry_t exp;
      exp.peer_id        = next_peer;
      exp.rpc_id         = RPC_ID_W'($urandom);
      exp.recv_pkts      = PKTS_W'(1);
      exp.grantable_pkts = PKTS_W'(len - 1);
      exp.state          = SRPT_ACTIVE;
      next_peer = next_peer + PEER_ID_W'(1);
      pending.push_back(exp);
      send_header(exp.peer_id, exp.rpc_id, len, int'($urandom % len), '0);
   endtask

   // msg_len not above incoming, dropped by the intake
   task automatic send_ignored();
      int len;
      len = int'($urandom % 64);
      send_header(PEER_ID_W'($urandom), RPC_ID_W'($urandom), len, len + int'($urandom % 4),
                  ($urandom % 2 == 0) ? 32'h0 : 32'h80);
   endtask

   // later packet of the oldest granted message
   task automatic retire_first();
      srpt_entry_t gone;
      gone = outstanding[0];
      send_header(gone.peer_id, gone.rpc_id, 10, 1, $urandom | 32'h1);
      // DUT slot frees at this edge
      @(posedge ap_clk);
      outstanding.delete(0);
   endtask

   task automatic wait_grants(input int target);
      int waited;
      waited = 0;
      while (grant_count < target) begin
         @(posedge ap_clk);
         waited++;
         if (waited > 4 * QUEUE_DEPTH) fail_run("an expected grant did not arrive in time");
      end
   endtask

   // each grant must match one pending message
   task automatic check_grant();
      int idx;
      int best;
      idx  = -1;
      best = 1 << PKTS_W;
      check_value("grant_full_i before grant_valid_o", 64'(full_at_edge), 64'd0);
      foreach (pending[k]) begin
         if (pending[k].peer_id == grant_o.peer_id && pending[k].rpc_id == grant_o.rpc_id) begin
            idx = k;
         end
         if (int'(pending[k].grantable_pkts) < best) begin
            best = int'(pending[k].grantable_pkts);
         end
      end
      if (idx < 0) fail_run("grant for a message that is not pending");
      check_value("grant_o", 64'(grant_o), 64'(pending[idx]));
      // settled queue, head is the smallest pending
      if (strict_order) begin
         check_value("grant_o.grantable_pkts", 64'(grant_o.grantable_pkts), 64'(best));
      end
      if (outstanding.size() >= MAX_OVERCOMMIT) fail_run("more than MAX_OVERCOMMIT grants out");
      outstanding.push_back(pending[idx]);
      pending.delete(idx);
      grant_count++;
   endtask

   // grant path state of the cycle that raised the pop
   always @(posedge ap_clk) begin
      full_at_edge = grant_full_i;
   end

   always @(negedge ap_clk) begin
      if (UUT.u_chk.assert_fails != 0) begin
         fail_run("a bound assertion failed during the run");
      end
      if (grant_valid_o === 1'b1) begin
         check_grant();
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
      fail_run("watchdog expired before all tests finished");
   end

   initial begin
      int          sent;
      int          len;
      int          kind;
      bit          len_used [1024];
      srpt_entry_t miss;
      void'($urandom(32'hb262));
      ap_rst         = 1'b1;
      header_valid_i = 1'b0;
      header_i       = '0;
      grant_full_i   = 1'b0;
      repeat (16) @(posedge ap_clk);
      @(negedge ap_clk);
      ap_rst = 1'b0;

      // quiet after reset
      idle(50);
      check_value("grant count", 64'(grant_count), 64'd0);

      // dropped headers and retires that match nothing
      for (int k = 0; k < 4; k++) begin
         send_ignored();
         send_header(PEER_ID_W'(16383 - k), RPC_ID_W'($urandom), 8, 1, 32'h40);
      end
      idle(QUEUE_DEPTH);
      check_value("grant count", 64'(grant_count), 64'd0);

      // fill the queue under back-pressure, distinct lengths
      @(negedge ap_clk);
      grant_full_i = 1'b1;
      strict_order = 1'b1;
      sent = 0;
      while (sent < QUEUE_DEPTH) begin
         len = 2 + int'($urandom % 1000);
         if (!len_used[len]) begin
            len_used[len] = 1'b1;
            new_message(len);
            sent++;
         end
      end
      idle(QUEUE_DEPTH);
      check_value("grant count", 64'(grant_count), 64'd0);
      @(negedge ap_clk);
      grant_full_i = 1'b0;
      wait_grants(MAX_OVERCOMMIT);
      idle(QUEUE_DEPTH);
      check_value("grant count", 64'(grant_count), 64'(MAX_OVERCOMMIT));

      // retires that miss every slot by peer or by rpc
      for (int k = 0; k < MAX_OVERCOMMIT; k++) begin
         miss = outstanding[k];
         if (k % 2 == 0) begin
            miss.rpc_id = miss.rpc_id ^ RPC_ID_W'(1);
         end else begin
            miss.peer_id = miss.peer_id ^ PEER_ID_W'(14'h2000);
         end
         send_header(miss.peer_id, miss.rpc_id, 8, 1, 32'h40);
      end
      idle(QUEUE_DEPTH);
      check_value("grant count", 64'(grant_count), 64'(MAX_OVERCOMMIT));

      // every retire opens exactly one slot
      for (int k = 0; k < MAX_OVERCOMMIT; k++) begin
         retire_first();
         wait_grants(MAX_OVERCOMMIT + k + 1);
         idle(QUEUE_DEPTH);
         check_value("grant count", 64'(grant_count), 64'(MAX_OVERCOMMIT + k + 1));
      end

      // random mix, order no longer settled
      strict_order = 1'b0;
      for (int k = 0; k < MIX_HEADERS; k++) begin
         @(posedge ap_clk);
         kind = int'($urandom % 4);
         if (kind == 0 && pending.size() >= QUEUE_DEPTH) kind = 1;
         if (kind == 2 && outstanding.size() == 0) kind = 1;
         @(negedge ap_clk);
         grant_full_i = ($urandom % 3) == 0;
         case (kind)
            0: new_message(2 + int'($urandom % 500));
            1: send_ignored();
            2: retire_first();
            default: idle(1);
         endcase
      end

      // drain, retire until every message got its grant
      @(negedge ap_clk);
      grant_full_i = 1'b0;
      for (int k = 0; k < 4 * QUEUE_DEPTH && pending.size() > 0; k++) begin
         if (outstanding.size() > 0) retire_first();
         idle(4);
      end
      check_value("pending messages left", 64'(pending.size()), 64'd0);

      if (UUT.u_chk.assert_fails == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         fail_run("a bound assertion failed during the run");
      end
   end

endmodule

// File: bench/srpt_chk.sv
module srpt_chk (
   input logic                  ap_clk,
   input logic                  ap_rst,
   input logic                  grant_full_i,
   input logic                  grant_valid_i,
   input srpt_pkg::srpt_entry_t grant_i
);
   import srpt_pkg::*;

   // failures so far, watched by the testbench
   int assert_fails = 0;

   // pop needs an open grant path, grant follows one cycle later
   grant_after_open: assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_valid_i |-> !$past(grant_full_i))
   else begin
      assert_fails = assert_fails + 1;
      $error("grant_valid_o raised after a cycle with grant_full_i high");
   end

   // only occupied entries leave as grants
   grant_is_active: assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_valid_i |-> (grant_i.state == SRPT_ACTIVE))
   else begin
      assert_fails = assert_fails + 1;
      $error("grant_o carries a state other than SRPT_ACTIVE");
   end

   grant_valid_known: assert property (@(posedge ap_clk) disable iff (ap_rst)
      !$isunknown(grant_valid_i))
   else begin
      assert_fails = assert_fails + 1;
      $error("grant_valid_o is unknown");
   end

endmodule

bind srpt_grant_top srpt_chk u_chk (
   .ap_clk        (ap_clk),
   .ap_rst        (ap_rst),
   .grant_full_i  (grant_full_i),
   .grant_valid_i (grant_valid_o),
   .grant_i       (grant_o)
);

// File: bench/tb_clock.sv
module tb_clock #(
   parameter int PERIOD = 4
) (
   output logic clk_o
);

   // free running, starts low
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2) clk_o = ~clk_o;
      end
   end

endmodule

// File: rtl/srpt_grant_top.sv
module srpt_grant_top #(
   parameter int QUEUE_DEPTH    = 16,
   parameter int MAX_OVERCOMMIT = 4
) (
   input  logic                   ap_clk,
   input  logic                   ap_rst,
   input  logic                   header_valid_i,
   input  srpt_pkg::srpt_header_t header_i,
   input  logic                   grant_full_i,
   output logic                   grant_valid_o,
   output srpt_pkg::srpt_entry_t  grant_o
);
   import srpt_pkg::*;

   // intake to queue
   logic                 push;
   srpt_entry_t          push_entry;
   // intake to active set
   logic                 retire;
   logic [PEER_ID_W-1:0] retire_peer;
   logic [RPC_ID_W-1:0]  retire_rpc;
   // queue head and draw
   srpt_entry_t          head;
   logic                 pop;

   srpt_header_intake u_intake (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_valid_i (header_valid_i),
      .header_i       (header_i),
      .push_o         (push),
      .push_entry_o   (push_entry),
      .retire_o       (retire),
      .retire_peer_o  (retire_peer),
      .retire_rpc_o   (retire_rpc)
   );

   // pending messages, best at the head
   srpt_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_queue (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .push_i       (push),
      .push_entry_i (push_entry),
      .pop_i        (pop),
      .head_o       (head)
   );

   // overcommit slots and grant output
   srpt_active_set #(
      .MAX_OVERCOMMIT (MAX_OVERCOMMIT)
   ) u_active (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .head_i        (head),
      .pop_o         (pop),
      .retire_i      (retire),
      .retire_peer_i (retire_peer),
      .retire_rpc_i  (retire_rpc),
      .grant_full_i  (grant_full_i),
      .grant_valid_o (grant_valid_o),
      .grant_o       (grant_o)
   );

endmodule

// File: rtl/srpt_active_set.sv
module srpt_active_set #(
   parameter int MAX_OVERCOMMIT = 4
) (
   input  logic                           ap_clk,
   input  logic                           ap_rst,
   input  srpt_pkg::srpt_entry_t          head_i,
   output logic                           pop_o,
   input  logic                           retire_i,
   input  logic [srpt_pkg::PEER_ID_W-1:0] retire_peer_i,
   input  logic [srpt_pkg::RPC_ID_W-1:0]  retire_rpc_i,
   input  logic                           grant_full_i,
   output logic                           grant_valid_o,
   output srpt_pkg::srpt_entry_t          grant_o
);
   import srpt_pkg::*;

   localparam int SLOT_W = (MAX_OVERCOMMIT > 1) ? $clog2(MAX_OVERCOMMIT) : 1;

   // messages currently granted
   srpt_entry_t       slot_q [MAX_OVERCOMMIT];

   // slot holding the retiring message
   logic [SLOT_W-1:0] match_idx;
   logic              match_hit;
   // lowest empty slot
   logic [SLOT_W-1:0] free_idx;
   logic              free_hit;
   logic              head_occupied;

   // retire lookup on peer and rpc
   // empty slots never match
   always_comb begin
      match_idx = '0;
      match_hit = 1'b0;
      for (int k = 0; k < MAX_OVERCOMMIT; k++) begin
         if (!match_hit &&
             slot_q[k].state != SRPT_EMPTY &&
             slot_q[k].peer_id == retire_peer_i &&
             slot_q[k].rpc_id == retire_rpc_i) begin
            match_idx = SLOT_W'(k);
            match_hit = 1'b1;
         end
      end
   end

   // priority pick of a free slot, lowest index wins
   always_comb begin
      free_idx = '0;
      free_hit = 1'b0;
      for (int k = 0; k < MAX_OVERCOMMIT; k++) begin
         if (!free_hit && slot_q[k].state == SRPT_EMPTY) begin
            free_idx = SLOT_W'(k);
            free_hit = 1'b1;
         end
      end
   end

   assign head_occupied = (head_i.state != SRPT_EMPTY);

   // draw the queue head when there is room and the grant path is open
   assign pop_o = head_occupied && free_hit && !grant_full_i;

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int k = 0; k < MAX_OVERCOMMIT; k++) begin
            slot_q[k] <= SRPT_ENTRY_NONE;
         end
         grant_valid_o <= 1'b0;
         grant_o       <= '0;
      end else begin
         // retired slot frees at this edge
         // a matched slot is occupied, so it is never the load target
         if (retire_i && match_hit) begin
            slot_q[match_idx] <= SRPT_ENTRY_NONE;
         end
         if (pop_o) begin
            slot_q[free_idx] <= head_i;
            grant_o          <= head_i;
         end
         // grant leaves one cycle after the pop
         grant_valid_o <= pop_o;
      end
   end

endmodule

// File: rtl/srpt_queue.sv
module srpt_queue #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  push_i,
   input  srpt_pkg::srpt_entry_t push_entry_i,
   input  logic                  pop_i,
   output srpt_pkg::srpt_entry_t head_o
);
   import srpt_pkg::*;

   // stored entries, index 0 is the head
   srpt_entry_t queue_q [QUEUE_DEPTH];

   // combinational stages, none of these are registers
   // after pop shift
   srpt_entry_t base_q [QUEUE_DEPTH];
   // after top insertion compare
   srpt_entry_t ins_q [QUEUE_DEPTH];
   // after even pair pass
   srpt_entry_t even_q [QUEUE_DEPTH];
   // after odd pair pass
   srpt_entry_t odd_q [QUEUE_DEPTH];

   // a strictly better than b
   // occupied beats empty, then fewer grantable packets
   // ties return 0 so the current order holds
   function automatic logic entry_better(input srpt_entry_t a, input srpt_entry_t b);
      logic a_occ;
      logic b_occ;
      a_occ = (a.state != SRPT_EMPTY);
      b_occ = (b.state != SRPT_EMPTY);
      if (a_occ != b_occ) begin
         return a_occ;
      end
      return a_occ && (a.grantable_pkts < b.grantable_pkts);
   endfunction

   assign head_o = queue_q[0];

   // pop drops the head and moves everything up one
   always_comb begin
      for (int k = 0; k < QUEUE_DEPTH - 1; k++) begin
         base_q[k] = pop_i ? queue_q[k + 1] : queue_q[k];
      end
      // bottom refills with an empty entry on pop
      base_q[QUEUE_DEPTH - 1] = pop_i ? SRPT_ENTRY_NONE : queue_q[QUEUE_DEPTH - 1];
   end

   // push goes in at the top
   // new entry is compared against the current top
   // with a pop in the same cycle that top is the old second entry
   always_comb begin
      ins_q = base_q;
      if (push_i) begin
         if (entry_better(push_entry_i, base_q[0])) begin
            ins_q[0] = push_entry_i;
            ins_q[1] = base_q[0];
         end else begin
            ins_q[0] = base_q[0];
            ins_q[1] = push_entry_i;
         end
         // rest slides down, bottom entry falls off when full
         for (int k = 2; k < QUEUE_DEPTH; k++) begin
            ins_q[k] = base_q[k - 1];
         end
      end
   end

   // even pass, pairs 0/1, 2/3, ...
   always_comb begin
      even_q = ins_q;
      for (int k = 0; k + 1 < QUEUE_DEPTH; k += 2) begin
         if (entry_better(ins_q[k + 1], ins_q[k])) begin
            even_q[k]     = ins_q[k + 1];
            even_q[k + 1] = ins_q[k];
         end
      end
   end

   // odd pass, pairs 1/2, 3/4, ...
   // head is never touched here
   always_comb begin
      odd_q = even_q;
      for (int k = 1; k + 1 < QUEUE_DEPTH; k += 2) begin
         if (entry_better(even_q[k + 1], even_q[k])) begin
            odd_q[k]     = even_q[k + 1];
            odd_q[k + 1] = even_q[k];
         end
      end
   end

   // one full odd/even round per clock
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int k = 0; k < QUEUE_DEPTH; k++) begin
            queue_q[k] <= SRPT_ENTRY_NONE;
         end
      end else begin
         for (int k = 0; k < QUEUE_DEPTH; k++) begin
            queue_q[k] <= odd_q[k];
         end
      end
   end

endmodule

// File: rtl/srpt_header_intake.sv
module srpt_header_intake (
   input  logic                           ap_clk,
   input  logic                           ap_rst,
   input  logic                           header_valid_i,
   input  srpt_pkg::srpt_header_t         header_i,
   output logic                           push_o,
   output srpt_pkg::srpt_entry_t          push_entry_o,
   output logic                           retire_o,
   output logic [srpt_pkg::PEER_ID_W-1:0] retire_peer_o,
   output logic [srpt_pkg::RPC_ID_W-1:0]  retire_rpc_o
);
   import srpt_pkg::*;

   // header still has packets to grant
   logic hdr_useful;
   // first unscheduled packet opens the message
   logic hdr_first;
   srpt_entry_t new_entry;

   assign hdr_useful = header_i.msg_len > header_i.incoming;
   assign hdr_first  = (header_i.offset == '0);

   // entry for a freshly opened message
   // one packet already in, the rest grantable
   always_comb begin
      new_entry.peer_id        = header_i.peer_id;
      new_entry.rpc_id         = header_i.rpc_id;
      new_entry.recv_pkts      = PKTS_W'(1);
      new_entry.grantable_pkts = header_i.msg_len - PKTS_W'(1);
      new_entry.state          = SRPT_ACTIVE;
   end

   // request strobes, one cycle after the header strobe
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         push_o   <= 1'b0;
         retire_o <= 1'b0;
      end else begin
         push_o   <= header_valid_i && hdr_useful && hdr_first;
         // later packet of the message retires its slot
         retire_o <= header_valid_i && hdr_useful && !hdr_first;
      end
   end

   // payload, only meaningful with its strobe
   always_ff @(posedge ap_clk) begin
      if (header_valid_i) begin
         push_entry_o  <= new_entry;
         retire_peer_o <= header_i.peer_id;
         retire_rpc_o  <= header_i.rpc_id;
      end
   end

endmodule

// File: rtl/srpt_pkg.sv
package srpt_pkg;

   // field widths
   localparam int PEER_ID_W = 14;
   localparam int RPC_ID_W = 14;
   localparam int PKTS_W = 10;
   localparam int OFFSET_W = 32;

   // slot and queue entry state
   // codes match the full scheduler, only two are used here
   typedef enum logic [2:0] {
      SRPT_EMPTY  = 3'b100,
      SRPT_ACTIVE = 3'b110
   } srpt_state_t;

   // incoming data packet header, 80 bits
   typedef struct packed {
      logic [PEER_ID_W-1:0] peer_id;
      logic [RPC_ID_W-1:0]  rpc_id;
      // total message length in packets
      logic [PKTS_W-1:0]    msg_len;
      // packets sent unscheduled
      logic [PKTS_W-1:0]    incoming;
      // byte offset of this packet in the message
      logic [OFFSET_W-1:0]  offset;
   } srpt_header_t;

   // queue / active set entry, 51 bits
   typedef struct packed {
      logic [PEER_ID_W-1:0] peer_id;
      logic [RPC_ID_W-1:0]  rpc_id;
      logic [PKTS_W-1:0]    recv_pkts;
      // packets still to be granted, sort key
      logic [PKTS_W-1:0]    grantable_pkts;
      srpt_state_t          state;
   } srpt_entry_t;

   // unoccupied entry
   // all fields zero except the state code
   localparam srpt_entry_t SRPT_ENTRY_NONE = '{
      peer_id:        '0,
      rpc_id:         '0,
      recv_pkts:      '0,
      grantable_pkts: '0,
      state:          SRPT_EMPTY
   };

endpackage
